// File: rtl/lanzones_macros.svh
`ifndef LANZONES_MACROS_SVH
`define LANZONES_MACROS_SVH

// datapath widths
`define XLEN      32
`define REG_COUNT 32
`define REG_AW    5

// major opcodes in bits [6:0]
`define OP_IMM    7'b0010011
`define OP_LUI    7'b0110111
`define OP_REG    7'b0110011
`define OP_STORE  7'b0100011
`define OP_LOAD   7'b0000011

// custom stop opcode
`define OP_HALT   7'h7F

`endif

// File: rtl/lanzonesPkg.sv
`default_nettype none

`include "lanzones_macros.svh"

package lanzonesPkg;

   typedef logic [`XLEN-1:0] word_t;
   typedef logic [`XLEN-1:0] addr_t;   // word address, not byte
   typedef logic [`REG_AW-1:0] regIdx_t;

   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_XOR,
      ALU_OR,
      ALU_AND,
      ALU_SLT,
      ALU_SLTU,
      ALU_SLL,
      ALU_SRL,
      ALU_SRA,
      ALU_PASSIMM   // lui
   } aluOp_t;

   typedef enum logic [2:0] {
      KIND_NONE,
      KIND_ALU,
      KIND_LOAD,
      KIND_STORE,
      KIND_HALT,
      KIND_INVALID
   } instrKind_t;

   typedef struct packed {
      instrKind_t kind;
      aluOp_t     aluOp;
      logic       useImm;   // operand b from imm instead of rs2
      regIdx_t    rs1;
      regIdx_t    rs2;
      regIdx_t    rd;
      word_t      imm;
   } decoded_t;

endpackage

`default_nettype wire

// File: rtl/regFileIf.sv
`timescale 1ns/1ps
`default_nettype none

interface regFileIf;

   lanzonesPkg::regIdx_t rs1;
   lanzonesPkg::regIdx_t rs2;
   lanzonesPkg::word_t   rs1Data;
   lanzonesPkg::word_t   rs2Data;

   logic                 wEn;
   lanzonesPkg::regIdx_t wAddr;
   lanzonesPkg::word_t   wData;

   modport exec (
      output rs1, rs2, wEn, wAddr, wData,
      input  rs1Data, rs2Data
   );

   modport regs (
      input  rs1, rs2, wEn, wAddr, wData,
      output rs1Data, rs2Data
   );

endinterface

`default_nettype wire

// File: rtl/memSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module memSequencer (
   input  logic                  clk,
   input  logic                  rstn,
   input  logic                  LEn,
   input  logic                  RVld,
   input  lanzonesPkg::word_t    RData,
   input  lanzonesPkg::decoded_t decoded,
   input  lanzonesPkg::word_t    memAddr,
   input  lanzonesPkg::word_t    storeData,
   output logic                  RRdy,
   output logic                  RWEn,
   output lanzonesPkg::addr_t    RAddr,
   output lanzonesPkg::word_t    RWData,
   output logic                  Halt,
   output lanzonesPkg::word_t    instr,
   output logic                  instrValid,
   output lanzonesPkg::word_t    loadData,
   output logic                  loadValid
);

   typedef enum logic [2:0] {
      SEQ_IDLE,
      SEQ_FETCH,
      SEQ_EXECUTE,
      SEQ_DATA_ACCESS,
      SEQ_HALTED
   } seqState_t;

   seqState_t          state;
   lanzonesPkg::addr_t pc;
   logic               reqDone;

   assign reqDone    = RRdy & RVld;   // RVld only counts with a request open
   assign instrValid = (state == SEQ_EXECUTE);
   assign loadData   = RData;
   assign loadValid  = (state == SEQ_DATA_ACCESS) & reqDone & ~RWEn;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= SEQ_IDLE;
         pc    <= '0;
         RRdy  <= 1'b0;
         RWEn  <= 1'b0;
         Halt  <= 1'b1;
      end else if (LEn) begin
         // relaunch from address 0 and abort anything in progress
         state <= SEQ_FETCH;
         pc    <= '0;
         RRdy  <= 1'b1;
         RWEn  <= 1'b0;
         Halt  <= 1'b0;
      end else begin
         case (state)
            SEQ_FETCH: begin
               if (!RRdy) begin
                  RRdy <= 1'b1;   // reopen after a data access
               end else if (RVld) begin
                  RRdy  <= 1'b0;
                  pc    <= pc + 1'b1;
                  state <= SEQ_EXECUTE;
               end
            end
            SEQ_EXECUTE: begin
               case (decoded.kind)
                  lanzonesPkg::KIND_ALU: begin
                     RRdy  <= 1'b1;   // next fetch overlaps the write-back
                     state <= SEQ_FETCH;
                  end
                  lanzonesPkg::KIND_LOAD, lanzonesPkg::KIND_STORE: begin
                     RRdy  <= 1'b1;
                     RWEn  <= (decoded.kind == lanzonesPkg::KIND_STORE);
                     state <= SEQ_DATA_ACCESS;
                  end
                  default: begin   // halt, invalid
                     Halt  <= 1'b1;
                     state <= SEQ_HALTED;
                  end
               endcase
            end
            SEQ_DATA_ACCESS: begin
               if (RVld) begin
                  RRdy  <= 1'b0;
                  RWEn  <= 1'b0;
                  state <= SEQ_FETCH;
               end
            end
            default: ;   // idle and halted wait for LEn
         endcase
      end
   end

   // request address/data and the instruction register
   always_ff @(posedge clk) begin
      if (LEn) begin
         RAddr <= '0;
      end else if (state == SEQ_FETCH && !RRdy) begin
         RAddr <= pc;
      end else if (state == SEQ_EXECUTE) begin
         if (decoded.kind == lanzonesPkg::KIND_ALU) begin
            RAddr <= pc;
         end else begin
            RAddr <= memAddr;
         end
         RWData <= storeData;
      end
      if (state == SEQ_FETCH && reqDone) begin
         instr <= RData;
      end
   end

   reqHeld: assert property (@(posedge clk) disable iff (!rstn)
      RRdy && !RVld |=> RRdy)
      else $error("RRdy dropped before RVld");

   writeInReq: assert property (@(posedge clk) disable iff (!rstn)
      RWEn |-> RRdy)
      else $error("RWEn high without an open request");

endmodule

`default_nettype wire

// File: rtl/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "lanzones_macros.svh"

module instrDecoder (
   input  lanzonesPkg::word_t    instr,
   input  logic                  instrValid,
   output lanzonesPkg::decoded_t decoded
);

   logic [6:0]         opcode;
   logic [6:0]         funct7;
   logic [2:0]         funct3;
   lanzonesPkg::word_t immI;
   lanzonesPkg::word_t immS;
   lanzonesPkg::word_t immU;
   lanzonesPkg::word_t immShamt;

   assign opcode   = instr[6:0];
   assign funct3   = instr[14:12];
   assign funct7   = instr[31:25];
   assign immI     = {{20{instr[31]}}, instr[31:20]};
   assign immS     = {{20{instr[31]}}, instr[31:25], instr[11:7]};
   assign immU     = {{12{instr[31]}}, instr[31:12]};   // shifted up in execUnit
   assign immShamt = {27'b0, instr[24:20]};

   always_comb begin
      decoded.kind   = lanzonesPkg::KIND_NONE;
      decoded.aluOp  = lanzonesPkg::ALU_ADD;
      decoded.useImm = 1'b0;
      decoded.rs1    = instr[19:15];
      decoded.rs2    = instr[24:20];
      decoded.rd     = instr[11:7];
      decoded.imm    = '0;

      if (instrValid) begin
         case (opcode)
            `OP_IMM: begin
               decoded.kind   = lanzonesPkg::KIND_ALU;
               decoded.useImm = 1'b1;
               decoded.imm    = immI;
               case (funct3)
                  3'b000: decoded.aluOp = lanzonesPkg::ALU_ADD;
                  3'b010: decoded.aluOp = lanzonesPkg::ALU_SLT;
                  3'b011: decoded.aluOp = lanzonesPkg::ALU_SLTU;
                  3'b100: decoded.aluOp = lanzonesPkg::ALU_XOR;
                  3'b110: decoded.aluOp = lanzonesPkg::ALU_OR;
                  3'b111: decoded.aluOp = lanzonesPkg::ALU_AND;
                  3'b001: begin
                     decoded.aluOp = lanzonesPkg::ALU_SLL;
                     decoded.imm   = immShamt;
                     if (funct7 != 7'b0000000) decoded.kind = lanzonesPkg::KIND_INVALID;
                  end
                  default: begin   // 101 is srli/srai
                     decoded.imm = immShamt;
                     if (funct7 == 7'b0000000) begin
                        decoded.aluOp = lanzonesPkg::ALU_SRL;
                     end else if (funct7 == 7'b0100000) begin
                        decoded.aluOp = lanzonesPkg::ALU_SRA;
                     end else begin
                        decoded.kind = lanzonesPkg::KIND_INVALID;
                     end
                  end
               endcase
            end
            `OP_LUI: begin
               decoded.kind   = lanzonesPkg::KIND_ALU;
               decoded.aluOp  = lanzonesPkg::ALU_PASSIMM;
               decoded.useImm = 1'b1;
               decoded.imm    = immU;
            end
            `OP_REG: begin
               decoded.kind = lanzonesPkg::KIND_ALU;
               if (funct7 == 7'b0000000) begin
                  case (funct3)
                     3'b000: decoded.aluOp = lanzonesPkg::ALU_ADD;
                     3'b001: decoded.aluOp = lanzonesPkg::ALU_SLL;
                     3'b010: decoded.aluOp = lanzonesPkg::ALU_SLT;
                     3'b011: decoded.aluOp = lanzonesPkg::ALU_SLTU;
                     3'b100: decoded.aluOp = lanzonesPkg::ALU_XOR;
                     3'b110: decoded.aluOp = lanzonesPkg::ALU_OR;
                     3'b111: decoded.aluOp = lanzonesPkg::ALU_AND;
                     default: decoded.kind = lanzonesPkg::KIND_INVALID;   // no srl/sra
                  endcase
               end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                  decoded.aluOp = lanzonesPkg::ALU_SUB;
               end else begin
                  decoded.kind = lanzonesPkg::KIND_INVALID;
               end
            end
            `OP_STORE: begin
               decoded.imm  = immS;
               decoded.kind = (funct3 == 3'b010) ? lanzonesPkg::KIND_STORE
                                                 : lanzonesPkg::KIND_INVALID;
            end
            `OP_LOAD: begin
               decoded.imm  = immI;
               decoded.kind = (funct3 == 3'b010) ? lanzonesPkg::KIND_LOAD
                                                 : lanzonesPkg::KIND_INVALID;
            end
            `OP_HALT: decoded.kind = lanzonesPkg::KIND_HALT;
            default:  decoded.kind = lanzonesPkg::KIND_INVALID;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: rtl/execUnit.sv
`timescale 1ns/1ps
`default_nettype none

module execUnit (
   input  logic                  clk,
   input  logic                  rstn,
   input  lanzonesPkg::decoded_t decoded,
   input  lanzonesPkg::word_t    loadData,
   input  logic                  loadValid,
   output lanzonesPkg::word_t    memAddr,
   output lanzonesPkg::word_t    storeData,
   regFileIf.exec                regs
);

   lanzonesPkg::word_t   opA;
   lanzonesPkg::word_t   opB;
   lanzonesPkg::word_t   aluResult;
   logic [4:0]           shamt;
   lanzonesPkg::regIdx_t loadRd;

   assign regs.rs1  = decoded.rs1;
   assign regs.rs2  = decoded.rs2;
   assign opA       = regs.rs1Data;
   assign opB       = decoded.useImm ? decoded.imm : regs.rs2Data;
   assign shamt     = opB[4:0];
   assign memAddr   = regs.rs1Data + decoded.imm;   // word address
   assign storeData = regs.rs2Data;

   always_comb begin
      aluResult = '0;
      case (decoded.aluOp)
         lanzonesPkg::ALU_ADD:     aluResult = opA + opB;
         lanzonesPkg::ALU_SUB:     aluResult = opA - opB;
         lanzonesPkg::ALU_XOR:     aluResult = opA ^ opB;
         lanzonesPkg::ALU_OR:      aluResult = opA | opB;
         lanzonesPkg::ALU_AND:     aluResult = opA & opB;
         lanzonesPkg::ALU_SLT:     aluResult = {31'b0, $signed(opA) < $signed(opB)};
         lanzonesPkg::ALU_SLTU:    aluResult = {31'b0, opA < opB};
         lanzonesPkg::ALU_SLL:     aluResult = opA << shamt;
         lanzonesPkg::ALU_SRL:     aluResult = opA >> shamt;
         lanzonesPkg::ALU_SRA:     aluResult = $signed(opA) >>> shamt;
         lanzonesPkg::ALU_PASSIMM: aluResult = decoded.imm << 12;
         default: ;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         regs.wEn <= 1'b0;
      end else begin
         regs.wEn <= (decoded.kind == lanzonesPkg::KIND_ALU) | loadValid;
      end
   end

   // load and alu write-backs never coincide
   always_ff @(posedge clk) begin
      if (decoded.kind == lanzonesPkg::KIND_LOAD) begin
         loadRd <= decoded.rd;   // held until the data returns
      end
      if (loadValid) begin
         regs.wAddr <= loadRd;
         regs.wData <= loadData;
      end else begin
         regs.wAddr <= decoded.rd;
         regs.wData <= aluResult;
      end
   end

endmodule

`default_nettype wire

// File: rtl/regFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "lanzones_macros.svh"

module regFile (
   input  logic   clk,
   input  logic   rstn,
   regFileIf.regs regs
);

   lanzonesPkg::word_t regArray [`REG_COUNT];

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < `REG_COUNT; i++) begin
            regArray[i] <= '0;
         end
      end else if (regs.wEn && regs.wAddr != '0) begin   // x0 stays zero
         regArray[regs.wAddr] <= regs.wData;
      end
   end

   assign regs.rs1Data = regArray[regs.rs1];
   assign regs.rs2Data = regArray[regs.rs2];

   x0Zero: assert property (@(posedge clk) disable iff (!rstn)
      regArray[0] == '0)
      else $error("x0 holds a nonzero value");

endmodule

`default_nettype wire

// File: rtl/lanzonesCore.sv
`timescale 1ns/1ps
`default_nettype none

`include "lanzones_macros.svh"

module lanzonesCore (
   input  logic             clk,
   input  logic             rstn,
   input  logic             RVld,
   input  logic [`XLEN-1:0] RData,
   output logic [`XLEN-1:0] RWData,
   output logic             RWEn,
   output logic             RRdy,
   output logic [`XLEN-1:0] RAddr,
   output logic             Halt,
   input  logic             LEn
);

   lanzonesPkg::word_t    instr;
   logic                  instrValid;
   lanzonesPkg::decoded_t decoded;
   lanzonesPkg::word_t    memAddr;
   lanzonesPkg::word_t    storeData;
   lanzonesPkg::word_t    loadData;
   logic                  loadValid;

   regFileIf rfBus ();

   memSequencer memSequencer_i (
      .clk        (clk),
      .rstn       (rstn),
      .LEn        (LEn),
      .RVld       (RVld),
      .RData      (RData),
      .decoded    (decoded),
      .memAddr    (memAddr),
      .storeData  (storeData),
      .RRdy       (RRdy),
      .RWEn       (RWEn),
      .RAddr      (RAddr),
      .RWData     (RWData),
      .Halt       (Halt),
      .instr      (instr),
      .instrValid (instrValid),
      .loadData   (loadData),
      .loadValid  (loadValid)
   );

   instrDecoder instrDecoder_i (
      .instr      (instr),
      .instrValid (instrValid),
      .decoded    (decoded)
   );

   execUnit execUnit_i (
      .clk       (clk),
      .rstn      (rstn),
      .decoded   (decoded),
      .loadData  (loadData),
      .loadValid (loadValid),
      .memAddr   (memAddr),
      .storeData (storeData),
      .regs      (rfBus.exec)
   );

   regFile regFile_i (
      .clk  (clk),
      .rstn (rstn),
      .regs (rfBus.regs)
   );

endmodule

`default_nettype wire

// File: verification/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen (
   output logic clk,
   output logic rstn
);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;   // 4 ns period
   end

   // held low over the first four rising edges, released on a falling edge
   initial begin
      rstn = 1'b0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      rstn = 1'b1;
   end

endmodule

`default_nettype wire

// File: verification/lanzonesTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "lanzones_macros.svh"

module lanzonesTb;

   localparam int TEST_COUNT = 6;

   logic               clk;
   logic               rstn;
   logic               LEn;
   logic               RVld = 1'b0;
   lanzonesPkg::word_t RData = '0;
   lanzonesPkg::word_t RWData;
   logic               RWEn;
   logic               RRdy;
   lanzonesPkg::addr_t RAddr;
   logic               Halt;

   lanzonesPkg::word_t mem [256];   // word addressed
   lanzonesPkg::word_t expected [12];
   lanzonesPkg::addr_t lastStoreAddr;
   int                 storeCount = 0;
   int                 progLen = 0;
   int                 errors = 0;
   int                 delayLeft = 0;
   logic               reqPending = 1'b0;
   int unsigned        lcgState = 974;

   clockGen clockGen_i (.clk(clk), .rstn(rstn));

   lanzonesCore lanzonesCore_i (.*);

   function automatic int unsigned nextRand();
      lcgState = lcgState * 32'd1103515245 + 32'd12345;
      return lcgState >> 16;
   endfunction

   // memory model answering each request after 0 to 3 extra cycles
   always @(negedge clk) begin
      if (RVld) begin
         RVld <= 1'b0;   // taken at the last rising edge
      end else if (RRdy) begin
         if (!reqPending) begin
            reqPending = 1'b1;
            delayLeft  = int'(nextRand() % 4);
         end
         if (delayLeft == 0) begin
            reqPending = 1'b0;
            if (RWEn) begin
               mem[RAddr[7:0]] = RWData;
               lastStoreAddr   = RAddr;
               storeCount++;
            end else begin
               RData <= mem[RAddr[7:0]];
            end
            RVld <= 1'b1;
         end else begin
            delayLeft--;
         end
      end
   end

   function automatic lanzonesPkg::word_t fillValue(int a);
      return lanzonesPkg::word_t'(a) * 32'h9E3779B1 + 32'h5A17C3E1;
   endfunction

   function automatic lanzonesPkg::word_t rType(int f7, int rs2, int rs1, int f3, int rd);
      return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], `OP_REG};
   endfunction

   function automatic lanzonesPkg::word_t iType(int imm, int rs1, int f3, int rd,
                                                logic [6:0] op);
      return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
   endfunction

   function automatic lanzonesPkg::word_t sType(int imm, int rs2, int rs1);
      return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], `OP_STORE};
   endfunction

   function automatic lanzonesPkg::word_t uType(int imm, int rd);
      return {imm[19:0], rd[4:0], `OP_LUI};
   endfunction

   function automatic lanzonesPkg::word_t haltWord();
      return {25'b0, `OP_HALT};
   endfunction

   task automatic checkWord(string name, lanzonesPkg::word_t exp, lanzonesPkg::word_t act);
      if (act !== exp) begin
         errors++;
         $display("** Error %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic checkAddr(string name, lanzonesPkg::addr_t exp, lanzonesPkg::addr_t act);
      if (act !== exp) begin
         errors++;
         $display("** Error %s: expected address %h, actual %h", name, exp, act);
      end
   endtask

   task automatic compareRange(string name, int base, int count);
      for (int i = 0; i < count; i++) begin
         checkWord($sformatf("%s word %0d", name, base + i), expected[i], mem[base + i]);
      end
   endtask

   task automatic resetMemory();
      @(negedge clk);
      for (int i = 0; i < 256; i++) mem[i] = fillValue(i);
      progLen = 0;
   endtask

   task automatic emit(lanzonesPkg::word_t w);
      mem[progLen] = w;
      progLen++;
   endtask

   task automatic launch();
      @(negedge clk);
      LEn = 1'b1;
      @(negedge clk);
      LEn = 1'b0;
   endtask

   task automatic waitHalt(string name);
      int cycles;
      cycles = 0;
      while (!Halt && cycles < 400) begin
         @(negedge clk);
         cycles++;
      end
      if (!Halt) begin
         errors++;
         $display("%s: core did not halt within 400 cycles", name);
      end
   endtask

   task automatic runProgram(string name);
      launch();
      waitHalt(name);
   endtask

   task automatic idleBeforeLaunch();
      int badCycles;
      badCycles = 0;
      resetMemory();
      emit(haltWord());
      repeat (20) begin
         @(negedge clk);
         if (RRdy || !Halt) badCycles++;
      end
      if (badCycles != 0) begin
         errors++;
         $display("idle: core left idle before LEn in %0d cycles", badCycles);
      end
      launch();
      if (!RRdy) begin
         errors++;
         $display("idle: no fetch request open right after LEn");
      end
      checkAddr("idle first fetch", '0, RAddr);
      waitHalt("idle");
   endtask

   task automatic regAluOps();
      int f7 [8] = '{0, 32, 0, 0, 0, 0, 0, 0};
      int f3 [8] = '{0, 0, 4, 6, 7, 2, 3, 1};
      lanzonesPkg::word_t a;
      lanzonesPkg::word_t b;
      resetMemory();
      emit(uType('h80000, 1));
      emit(iType(5, 1, 0, 1, `OP_IMM));
      emit(iType(3, 0, 0, 2, `OP_IMM));
      for (int i = 0; i < 8; i++) emit(rType(f7[i], 2, 1, f3[i], 3 + i));
      emit(rType(0, 1, 2, 2, 11));   // operands swapped
      emit(rType(0, 1, 2, 3, 12));
      for (int i = 0; i < 10; i++) emit(sType(64 + i, 3 + i, 0));
      emit(haltWord());
      runProgram("r-type");
      a = (32'h80000 << 12) + 5;
      b = 3;
      expected[0] = a + b;
      expected[1] = a - b;
      expected[2] = a ^ b;
      expected[3] = a | b;
      expected[4] = a & b;
      expected[5] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      expected[6] = (a < b) ? 32'd1 : 32'd0;
      expected[7] = a << b[4:0];
      expected[8] = ($signed(b) < $signed(a)) ? 32'd1 : 32'd0;
      expected[9] = (b < a) ? 32'd1 : 32'd0;
      compareRange("r-type", 64, 10);
   endtask

   task automatic immAluOps();
      int f3 [9]  = '{0, 4, 6, 7, 2, 3, 1, 5, 5};
      int imm [9] = '{-7, 'h0F0, 'h123, 'h7F0, -3, 5, 4, 4, 'h404};   // last one srai
      lanzonesPkg::word_t a;
      resetMemory();
      emit(iType(-20, 0, 0, 1, `OP_IMM));
      for (int i = 0; i < 9; i++) emit(iType(imm[i], 1, f3[i], 2 + i, `OP_IMM));
      emit(uType('hABCDE, 11));
      for (int i = 0; i < 11; i++) emit(sType(80 + i, 1 + i, 0));
      emit(haltWord());
      runProgram("i-type");
      a = -20;
      expected[0]  = a;
      expected[1]  = a - 7;
      expected[2]  = a ^ 32'h0F0;
      expected[3]  = a | 32'h123;
      expected[4]  = a & 32'h7F0;
      expected[5]  = ($signed(a) < -3) ? 32'd1 : 32'd0;
      expected[6]  = (a < 32'd5) ? 32'd1 : 32'd0;
      expected[7]  = a << 4;
      expected[8]  = a >> 4;
      expected[9]  = $signed(a) >>> 4;
      expected[10] = 32'hABCDE << 12;
      compareRange("i-type", 80, 11);
   endtask

   task automatic loadThenUse();
      lanzonesPkg::word_t preset;
      preset = 32'h12345678;
      resetMemory();
      mem[100] = preset;
      emit(iType(90, 0, 0, 1, `OP_IMM));
      emit(iType(10, 1, 2, 2, `OP_LOAD));    // lw x2, 10(x1)
      emit(iType('h111, 2, 0, 3, `OP_IMM));
      emit(sType(21, 2, 1));
      emit(sType(20, 3, 1));
      emit(haltWord());
      runProgram("load-use");
      expected[0] = preset + 32'h111;
      expected[1] = preset;
      compareRange("load-use", 110, 2);
      checkAddr("load-use store address", 90 + 20, lastStoreAddr);
   endtask

   task automatic zeroRegister();
      resetMemory();
      emit(iType(55, 0, 0, 0, `OP_IMM));
      emit(uType('hFFFFF, 0));
      emit(sType(120, 0, 0));
      emit(haltWord());
      runProgram("x0");
      expected[0] = '0;
      compareRange("x0", 120, 1);
   endtask

   task automatic invalidHalt();
      int storesBefore;
      resetMemory();
      emit(iType(77, 0, 0, 1, `OP_IMM));
      emit(sType(130, 1, 0));
      emit(rType(1, 1, 1, 0, 4));   // funct7 01 is outside the subset
      emit(sType(131, 1, 0));
      emit(haltWord());
      storesBefore = storeCount;
      runProgram("invalid");
      if (storeCount != storesBefore + 1) begin
         errors++;
         $display("invalid: %0d stores reached memory, one expected", storeCount - storesBefore);
      end
      expected[0] = 77;
      expected[1] = fillValue(131);
      compareRange("invalid", 130, 2);
      mem[130] = fillValue(130);
      launch();
      checkAddr("relaunch first fetch", '0, RAddr);
      waitHalt("relaunch");
      compareRange("relaunch", 130, 2);
   endtask

   initial begin
      LEn = 1'b0;
      wait (rstn === 1'b1);
      idleBeforeLaunch();
      regAluOps();
      immAluOps();
      loadThenUse();
      zeroRegister();
      invalidHalt();
      $display("errors: %0d", errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

   // watchdog
   initial begin
      #(TEST_COUNT * 2000);
      $display("watchdog: tests still running after %0d ns", TEST_COUNT * 2000);
      $display("Regression failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: compile.f
+incdir+rtl
rtl/lanzonesPkg.sv
rtl/regFileIf.sv
rtl/memSequencer.sv
rtl/instrDecoder.sv
rtl/execUnit.sv
rtl/regFile.sv
rtl/lanzonesCore.sv
verification/clockGen.sv
verification/lanzonesTb.sv

// File: Makefile
SRCS := $(filter-out +%,$(shell cat compile.f)) rtl/lanzones_macros.svh

.PHONY: run clean

run: obj_dir/VlanzonesTb
	@out="$$(./obj_dir/VlanzonesTb)"; echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

obj_dir/VlanzonesTb: compile.f $(SRCS)
	verilator --binary --timing --top-module lanzonesTb -f compile.f -o VlanzonesTb

clean:
	rm -rf obj_dir
